// File: all.f
+incdir+hdl
hdl/rv_decoder_pkg.sv
hdl/rv_imm_gen.sv
hdl/rv_hazard_unit.sv
hdl/rv_decode_ctrl.sv
hdl/rv_decode_reg.sv
hdl/rv_decoder_top.sv
tb/tb_rv_decoder.sv

// File: hdl/rv_decode_ctrl.sv
////////////////////////////////////////
// Decode control
// Opcode decode, next-value fields and
// the load/store sequencing FSM
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "rv_decoder_consts.svh"

module rv_decode_ctrl
  import rv_decoder_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  word_t     instr_i,
  input  logic      instr_valid_i,
  input  logic      hazard_i,
  output logic      ready_o,
  output logic      stall_o,
  output logic      use_rs1_o,
  output logic      use_rs2_o,
  output imm_sel_t  imm_sel_o,
  output logic      use_pc_o,
  output logic      illegal_o,
  output alu_sel_t  alu_sel_o,
  output logic      alu_op_a_o,
  output logic      alu_op_b_o,
  output reg_addr_t alu_dest_o,
  output logic      alu_wb_o,
  output reg_addr_t rf_addr_a_o,
  output reg_addr_t rf_addr_b_o,
  output logic      lsu_valid_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output reg_addr_t lsu_regdest_o
);

  dec_state_t  curr_state;
  dec_state_t  prev_state;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_state <= ST_IDLE;
    end else begin
      prev_state <= curr_state;
    end
  end

  // Ready only in the last cycle of an instruction, or when idle
  assign ready_o = (curr_state == ST_OK) || (curr_state == ST_LD_WAIT2) ||
                   (curr_state == ST_ST_REQ) || (curr_state == ST_IDLE);
  assign stall_o = (curr_state == ST_STALL);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  always_comb begin
    curr_state    = ST_IDLE;
    use_rs1_o     = 1'b0;
    use_rs2_o     = 1'b0;
    imm_sel_o     = IMM_NONE;
    use_pc_o      = 1'b0;
    illegal_o     = 1'b0;
    alu_sel_o     = `ALU_OP_ADD;
    alu_op_a_o    = 1'b0;
    alu_op_b_o    = 1'b0;
    alu_dest_o    = '0;
    alu_wb_o      = 1'b0;
    rf_addr_a_o   = '0;
    rf_addr_b_o   = '0;
    lsu_valid_o   = 1'b0;
    lsu_ctrl_o    = '0;
    lsu_regdest_o = '0;

    if (instr_valid_i) begin
      case (opcode)
        `OPCODE_OP: begin
          use_rs1_o   = 1'b1;
          use_rs2_o   = 1'b1;
          alu_sel_o   = {instr_i[30], funct3};
          alu_op_a_o  = 1'b1;
          alu_op_b_o  = 1'b1;
          alu_dest_o  = rd;
          rf_addr_a_o = rs1;
          rf_addr_b_o = rs2;
          alu_wb_o    = !hazard_i;  // No writeback in the stall cycle
          curr_state  = hazard_i ? ST_STALL : ST_OK;
        end
        `OPCODE_OPIMM: begin
          use_rs1_o   = 1'b1;
          alu_op_a_o  = 1'b1;
          alu_dest_o  = rd;
          rf_addr_a_o = rs1;
          if (funct3 == `FUNCT3_SHIFT_L || funct3 == `FUNCT3_SHIFT_R) begin
            imm_sel_o = IMM_SHIFT;
            alu_sel_o = {instr_i[30], funct3};  // Bit 30 picks SRAI
          end else begin
            imm_sel_o = IMM_I;
            alu_sel_o = {1'b0, funct3};
          end
          alu_wb_o   = !hazard_i;
          curr_state = hazard_i ? ST_STALL : ST_OK;
        end
        `OPCODE_LUI, `OPCODE_AUIPC: begin
          use_pc_o   = (opcode == `OPCODE_AUIPC);  // PC + imm, else x0 + imm
          imm_sel_o  = IMM_U;
          alu_op_a_o = 1'b1;
          alu_dest_o = rd;
          alu_wb_o   = 1'b1;
          curr_state = ST_OK;
        end
        `OPCODE_LOAD: begin
          use_rs1_o   = 1'b1;
          rf_addr_a_o = rs1;
          case (prev_state)
            ST_LD_ADDR: begin
              curr_state    = ST_LD_REQ;
              lsu_valid_o   = 1'b1;
              lsu_ctrl_o    = {opcode[5], funct3};
              lsu_regdest_o = rd;
            end
            ST_LD_REQ:   curr_state = ST_LD_WAIT0;
            ST_LD_WAIT0: curr_state = ST_LD_WAIT1;
            ST_LD_WAIT1: curr_state = ST_LD_WAIT2;
            default: begin
              // First cycle, address calc unless stalled
              if (hazard_i) begin
                curr_state = ST_STALL;
              end else begin
                curr_state = ST_LD_ADDR;
                alu_op_a_o = 1'b1;
                imm_sel_o  = IMM_I;
              end
            end
          endcase
        end
        `OPCODE_STORE: begin
          use_rs1_o   = 1'b1;
          use_rs2_o   = 1'b1;
          rf_addr_a_o = rs1;
          rf_addr_b_o = rs2;
          if (prev_state == ST_ST_ADDR) begin
            curr_state  = ST_ST_REQ;
            alu_op_b_o  = 1'b1;  // Store data from rs2
            lsu_valid_o = 1'b1;
            lsu_ctrl_o  = {opcode[5], funct3};
          end else if (hazard_i) begin
            curr_state = ST_STALL;
          end else begin
            curr_state = ST_ST_ADDR;
            alu_op_a_o = 1'b1;
            imm_sel_o  = IMM_S;
          end
        end
        `OPCODE_MISCMEM, `OPCODE_SYSTEM: begin
          curr_state = ST_OK;  // Treated as no-ops
        end
        default: begin
          illegal_o  = 1'b1;
          curr_state = ST_OK;
        end
      endcase
    end
  end

  // Sequencer state stays inside the encoded set
  a_state_legal : assert property (@(posedge clk_i) disable iff (!rstn_i)
    prev_state inside {ST_OK, ST_STALL, ST_LD_ADDR, ST_LD_REQ, ST_LD_WAIT0,
                       ST_LD_WAIT1, ST_LD_WAIT2, ST_ST_ADDR, ST_ST_REQ, ST_IDLE});

endmodule

`default_nettype wire

// File: hdl/rv_decode_reg.sv
////////////////////////////////////////
// Registered decode outputs
// Fields load on valid cycles, strobes
// drop while no instruction is valid
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rv_decode_reg
  import rv_decoder_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  word_t     instr_addr_i,
  input  logic      use_pc_i,
  input  logic      illegal_i,
  input  alu_sel_t  alu_sel_i,
  input  logic      alu_op_a_i,
  input  logic      alu_op_b_i,
  input  reg_addr_t alu_dest_i,
  input  logic      alu_wb_i,
  input  reg_addr_t rf_addr_a_i,
  input  reg_addr_t rf_addr_b_i,
  input  word_t     imm_i,
  input  logic      lsu_valid_i,
  input  lsu_ctrl_t lsu_ctrl_i,
  input  reg_addr_t lsu_regdest_i,
  output word_t     instr_addr_o,
  output logic      use_pc_o,
  output logic      illegal_instr_o,
  output alu_sel_t  alu_sel_o,
  output logic      alu_op_a_o,
  output logic      alu_op_b_o,
  output reg_addr_t alu_dest_addr_o,
  output logic      alu_wb_o,
  output reg_addr_t rf_addr_a_o,
  output reg_addr_t rf_addr_b_o,
  output logic      is_imm_o,
  output word_t     imm_ext_o,
  output logic      lsu_ctrl_valid_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output reg_addr_t lsu_regdest_o
);

  // Strobes
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      use_pc_o         <= 1'b0;
      illegal_instr_o  <= 1'b0;
      alu_wb_o         <= 1'b0;
      lsu_ctrl_valid_o <= 1'b0;
    end else if (instr_valid_i) begin
      use_pc_o         <= use_pc_i;
      illegal_instr_o  <= illegal_i;
      alu_wb_o         <= alu_wb_i;
      lsu_ctrl_valid_o <= lsu_valid_i;
    end else begin
      use_pc_o         <= 1'b0;
      alu_wb_o         <= 1'b0;
      lsu_ctrl_valid_o <= 1'b0;
    end
  end

  // Payload fields, held while not valid
  always_ff @(posedge clk_i) begin
    instr_addr_o <= instr_addr_i;  // Always one clock behind
    if (instr_valid_i) begin
      alu_sel_o       <= alu_sel_i;
      alu_op_a_o      <= alu_op_a_i;
      alu_op_b_o      <= alu_op_b_i;
      alu_dest_addr_o <= alu_dest_i;
      rf_addr_a_o     <= rf_addr_a_i;
      rf_addr_b_o     <= rf_addr_b_i;
      is_imm_o        <= !(alu_op_a_i && alu_op_b_i);
      imm_ext_o       <= imm_i;
      lsu_ctrl_o      <= lsu_ctrl_i;
      lsu_regdest_o   <= lsu_regdest_i;
    end
  end

  ////////////////////////////////////////
  // Checks on the output strobes
  ////////////////////////////////////////
  a_wb_lsu_excl : assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(alu_wb_o && lsu_ctrl_valid_o));

  // One LSU request per load or store sequence
  a_lsu_pulse : assert property (@(posedge clk_i) disable iff (!rstn_i)
    lsu_ctrl_valid_o |=> !lsu_ctrl_valid_o);

endmodule

`default_nettype wire

// File: hdl/rv_decoder_consts.svh
////////////////////////////////////////
// Width, opcode and function code
// defines for the RV32I decode stage
////////////////////////////////////////
`ifndef RV_DECODER_CONSTS_SVH
`define RV_DECODER_CONSTS_SVH

// Widths
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5

// RV32I major opcodes handled by the decoder
`define OPCODE_LOAD    7'b0000011
`define OPCODE_STORE   7'b0100011
`define OPCODE_OP      7'b0110011
`define OPCODE_OPIMM   7'b0010011
`define OPCODE_LUI     7'b0110111
`define OPCODE_AUIPC   7'b0010111
`define OPCODE_MISCMEM 7'b0001111
`define OPCODE_SYSTEM  7'b1110011

// Immediate shift funct3 codes (SLLI, SRLI/SRAI)
`define FUNCT3_SHIFT_L 3'b001
`define FUNCT3_SHIFT_R 3'b101

// ALU select for addition
`define ALU_OP_ADD 4'b0000

`endif

// File: hdl/rv_decoder_pkg.sv
////////////////////////////////////////
// Decoder types: word and field vectors,
// immediate kind and sequencer states
////////////////////////////////////////
`default_nettype none

`include "rv_decoder_consts.svh"

package rv_decoder_pkg;

  typedef logic [`DATA_WIDTH-1:0]     word_t;      // Instruction, address, immediate
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;  // Register index
  typedef logic [3:0]                 alu_sel_t;   // {instr[30], funct3}
  typedef logic [3:0]                 lsu_ctrl_t;  // {opcode[5], funct3}

  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_SHIFT,
    IMM_S,
    IMM_U
  } imm_sel_t;

  typedef enum logic [3:0] {
    ST_OK,        // Single cycle instruction done
    ST_STALL,     // RAW stall, instruction held
    ST_LD_ADDR,
    ST_LD_REQ,
    ST_LD_WAIT0,
    ST_LD_WAIT1,
    ST_LD_WAIT2,
    ST_ST_ADDR,
    ST_ST_REQ,
    ST_IDLE       // No valid instruction
  } dec_state_t;

endpackage

`default_nettype wire

// File: hdl/rv_decoder_top.sv
////////////////////////////////////////
// RV32I decode stage top level
// Control, immediate, hazard and output
// register blocks
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rv_decoder_top
  import rv_decoder_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  word_t     instr_i,
  input  word_t     instr_addr_i,
  input  logic      instr_valid_i,
  output logic      ready_o,
  output word_t     instr_addr_o,
  output logic      use_pc_o,
  output logic      illegal_instr_o,
  output alu_sel_t  alu_sel_o,
  output logic      alu_op_a_o,
  output logic      alu_op_b_o,
  output reg_addr_t alu_dest_addr_o,
  output logic      alu_wb_o,
  output reg_addr_t rf_addr_a_o,
  output reg_addr_t rf_addr_b_o,
  output logic      is_imm_o,
  output word_t     imm_ext_o,
  output logic      lsu_ctrl_valid_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output reg_addr_t lsu_regdest_o
);

  logic      hazard;
  logic      stall;
  logic      use_rs1;
  logic      use_rs2;
  imm_sel_t  imm_sel;
  word_t     imm;
  logic      use_pc;
  logic      illegal;
  alu_sel_t  alu_sel;
  logic      alu_op_a;
  logic      alu_op_b;
  reg_addr_t alu_dest;
  logic      alu_wb;
  reg_addr_t rf_addr_a;
  reg_addr_t rf_addr_b;
  logic      lsu_valid;
  lsu_ctrl_t lsu_ctrl;
  reg_addr_t lsu_regdest;

  rv_decode_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .hazard_i      (hazard),
    .ready_o       (ready_o),
    .stall_o       (stall),
    .use_rs1_o     (use_rs1),
    .use_rs2_o     (use_rs2),
    .imm_sel_o     (imm_sel),
    .use_pc_o      (use_pc),
    .illegal_o     (illegal),
    .alu_sel_o     (alu_sel),
    .alu_op_a_o    (alu_op_a),
    .alu_op_b_o    (alu_op_b),
    .alu_dest_o    (alu_dest),
    .alu_wb_o      (alu_wb),
    .rf_addr_a_o   (rf_addr_a),
    .rf_addr_b_o   (rf_addr_b),
    .lsu_valid_o   (lsu_valid),
    .lsu_ctrl_o    (lsu_ctrl),
    .lsu_regdest_o (lsu_regdest)
  );

  rv_imm_gen u_imm_gen (
    .instr_i   (instr_i),
    .imm_sel_i (imm_sel),
    .imm_o     (imm)
  );

  rv_hazard_unit u_hazard (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .use_rs1_i     (use_rs1),
    .use_rs2_i     (use_rs2),
    .stall_i       (stall),
    .hazard_o      (hazard)
  );

  rv_decode_reg u_out_reg (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_valid_i    (instr_valid_i),
    .instr_addr_i     (instr_addr_i),
    .use_pc_i         (use_pc),
    .illegal_i        (illegal),
    .alu_sel_i        (alu_sel),
    .alu_op_a_i       (alu_op_a),
    .alu_op_b_i       (alu_op_b),
    .alu_dest_i       (alu_dest),
    .alu_wb_i         (alu_wb),
    .rf_addr_a_i      (rf_addr_a),
    .rf_addr_b_i      (rf_addr_b),
    .imm_i            (imm),
    .lsu_valid_i      (lsu_valid),
    .lsu_ctrl_i       (lsu_ctrl),
    .lsu_regdest_i    (lsu_regdest),
    .instr_addr_o     (instr_addr_o),
    .use_pc_o         (use_pc_o),
    .illegal_instr_o  (illegal_instr_o),
    .alu_sel_o        (alu_sel_o),
    .alu_op_a_o       (alu_op_a_o),
    .alu_op_b_o       (alu_op_b_o),
    .alu_dest_addr_o  (alu_dest_addr_o),
    .alu_wb_o         (alu_wb_o),
    .rf_addr_a_o      (rf_addr_a_o),
    .rf_addr_b_o      (rf_addr_b_o),
    .is_imm_o         (is_imm_o),
    .imm_ext_o        (imm_ext_o),
    .lsu_ctrl_valid_o (lsu_ctrl_valid_o),
    .lsu_ctrl_o       (lsu_ctrl_o),
    .lsu_regdest_o    (lsu_regdest_o)
  );

endmodule

`default_nettype wire

// File: hdl/rv_hazard_unit.sv
////////////////////////////////////////
// Read-after-write hazard detection
// Tracks the last destination register
// and the previous stall cycle
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "rv_decoder_consts.svh"

module rv_hazard_unit
  import rv_decoder_pkg::*;
(
  input  logic  clk_i,
  input  logic  rstn_i,
  input  word_t instr_i,
  input  logic  instr_valid_i,
  input  logic  use_rs1_i,
  input  logic  use_rs2_i,
  input  logic  stall_i,
  output logic  hazard_o
);

  reg_addr_t prev_rd;
  logic      prev_stall;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rs1_hit;
  logic      rs2_hit;

  assign rd  = instr_i[11:7];
  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_rd    <= '0;
      prev_stall <= 1'b0;
    end else begin
      if (instr_valid_i && instr_i[6:0] != `OPCODE_STORE) begin
        prev_rd <= rd;
      end else begin
        prev_rd <= '0;  // Stores write no register
      end
      prev_stall <= stall_i;
    end
  end

  assign rs1_hit = use_rs1_i && (rs1 != '0) && (rs1 == prev_rd);
  assign rs2_hit = use_rs2_i && (rs2 != '0) && (rs2 == prev_rd);

  // One stall cycle is enough, never stall twice in a row
  assign hazard_o = (rs1_hit || rs2_hit) && !prev_stall;

endmodule

`default_nettype wire

// File: hdl/rv_imm_gen.sv
////////////////////////////////////////
// Immediate generator
// I, shift, S and U immediates, chosen
// by the immediate kind from control
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "rv_decoder_consts.svh"

module rv_imm_gen
  import rv_decoder_pkg::*;
(
  input  word_t    instr_i,
  input  imm_sel_t imm_sel_i,
  output word_t    imm_o
);

  // Sign extension of a 12 bit field
  function automatic word_t sext12(input logic [11:0] val);
    return {{(`DATA_WIDTH-12){val[11]}}, val};
  endfunction

  logic [11:0] imm_i_field;
  logic [11:0] imm_s_field;
  logic [4:0]  shamt;
  logic [19:0] imm_u_field;

  assign imm_i_field = instr_i[31:20];
  assign imm_s_field = {instr_i[31:25], instr_i[11:7]};  // Split around rd slot
  assign shamt       = instr_i[24:20];
  assign imm_u_field = instr_i[31:12];

  always_comb begin
    case (imm_sel_i)
      IMM_I: begin
        imm_o = sext12(imm_i_field);
      end
      IMM_SHIFT: begin
        imm_o = {{(`DATA_WIDTH-5){1'b0}}, shamt};  // Shift amount is unsigned
      end
      IMM_S: begin
        imm_o = sext12(imm_s_field);
      end
      IMM_U: begin
        imm_o = {imm_u_field, 12'b0};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: tb/tb_rv_decoder.sv
////////////////////////////////////////
// Testbench for the RV32I decode stage
// Directed and random instructions, a
// reference decode model, per-cycle
// output compare and a cycle timeout
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "rv_decoder_consts.svh"

module tb_rv_decoder
  import rv_decoder_pkg::*;
();

  // About 100 instructions at up to 6 cycles with a stall, plus idle gaps
  localparam int MAX_CYCLES = 600;

  // Expected view of one decode cycle, c_* bits enable a field compare
  typedef struct packed {
    logic      on;
    logic      rdy;
    logic      wb;
    logic      lsu_v;
    logic      use_pc;
    logic      illegal;
    word_t     addr;
    logic      c_alu;
    alu_sel_t  alu_sel;
    logic      c_imm;
    word_t     imm;
    logic      is_imm;
    logic      c_rf_a;
    reg_addr_t rf_a;
    logic      c_rf_b;
    reg_addr_t rf_b;
    logic      c_dest;
    reg_addr_t dest;
    logic      c_lsu;
    lsu_ctrl_t lsu;
    logic      c_lrd;
    reg_addr_t lsu_rd;
    logic      c_opb;
    logic      op_b;
    logic      c_opa;
    logic      op_a;
  } exp_t;

  logic      clk_i;
  logic      rstn_i;
  word_t     instr_i;
  word_t     instr_addr_i;
  logic      instr_valid_i;
  logic      ready_o;
  word_t     instr_addr_o;
  logic      use_pc_o;
  logic      illegal_instr_o;
  alu_sel_t  alu_sel_o;
  logic      alu_op_a_o;
  logic      alu_op_b_o;
  reg_addr_t alu_dest_addr_o;
  logic      alu_wb_o;
  reg_addr_t rf_addr_a_o;
  reg_addr_t rf_addr_b_o;
  logic      is_imm_o;
  word_t     imm_ext_o;
  logic      lsu_ctrl_valid_o;
  lsu_ctrl_t lsu_ctrl_o;
  reg_addr_t lsu_regdest_o;

  integer    seed = 39;
  int        err_count = 0;
  int        cycle_cnt = 0;
  exp_t      exp_next = '0;  // Cycle being driven now
  exp_t      exp_cur = '0;   // Cycle whose outputs are registered
  word_t     pc = 32'h0000_1000;
  reg_addr_t prev_rd_m = '0;  // Hazard model state
  logic      last_ill = 1'b0;

  rv_decoder_top uut (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_i          (instr_i),
    .instr_addr_i     (instr_addr_i),
    .instr_valid_i    (instr_valid_i),
    .ready_o          (ready_o),
    .instr_addr_o     (instr_addr_o),
    .use_pc_o         (use_pc_o),
    .illegal_instr_o  (illegal_instr_o),
    .alu_sel_o        (alu_sel_o),
    .alu_op_a_o       (alu_op_a_o),
    .alu_op_b_o       (alu_op_b_o),
    .alu_dest_addr_o  (alu_dest_addr_o),
    .alu_wb_o         (alu_wb_o),
    .rf_addr_a_o      (rf_addr_a_o),
    .rf_addr_b_o      (rf_addr_b_o),
    .is_imm_o         (is_imm_o),
    .imm_ext_o        (imm_ext_o),
    .lsu_ctrl_valid_o (lsu_ctrl_valid_o),
    .lsu_ctrl_o       (lsu_ctrl_o),
    .lsu_regdest_o    (lsu_regdest_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Failure handling and compare tasks
  ////////////////////////////////////////
  task automatic abort_run();
    err_count++;
    $display("Some tests failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp_v, input reg_addr_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_alu(input string name, input alu_sel_t exp_v, input alu_sel_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_lsu(input string name, input lsu_ctrl_t exp_v, input lsu_ctrl_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic compare_outputs(input exp_t e);
    check_bit("alu_wb_o", e.wb, alu_wb_o);
    check_bit("lsu_ctrl_valid_o", e.lsu_v, lsu_ctrl_valid_o);
    check_bit("use_pc_o", e.use_pc, use_pc_o);
    check_bit("illegal_instr_o", e.illegal, illegal_instr_o);
    check_word("instr_addr_o", e.addr, instr_addr_o);
    if (e.c_alu) check_alu("alu_sel_o", e.alu_sel, alu_sel_o);
    if (e.c_imm) begin
      check_word("imm_ext_o", e.imm, imm_ext_o);
      check_bit("is_imm_o", e.is_imm, is_imm_o);
    end
    if (e.c_rf_a) check_reg("rf_addr_a_o", e.rf_a, rf_addr_a_o);
    if (e.c_rf_b) check_reg("rf_addr_b_o", e.rf_b, rf_addr_b_o);
    if (e.c_dest) check_reg("alu_dest_addr_o", e.dest, alu_dest_addr_o);
    if (e.c_lsu) check_lsu("lsu_ctrl_o", e.lsu, lsu_ctrl_o);
    if (e.c_lrd) check_reg("lsu_regdest_o", e.lsu_rd, lsu_regdest_o);
    if (e.c_opa) check_bit("alu_op_a_o", e.op_a, alu_op_a_o);
    if (e.c_opb) check_bit("alu_op_b_o", e.op_b, alu_op_b_o);
  endtask

  // Ready is checked for the cycle in flight, outputs for the one before
  always @(negedge clk_i) begin
    if (exp_next.on) check_bit("ready_o", exp_next.rdy, ready_o);
    if (exp_cur.on) compare_outputs(exp_cur);
    exp_cur = exp_next;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the decoder stopped accepting instructions",
               cycle_cnt);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Reference decode model
  ////////////////////////////////////////
  // Expected outputs of the first decode cycle without a stall
  function automatic exp_t decode_model(input word_t instr);
    exp_t       e;
    logic [6:0] opc;
    logic [2:0] f3;
    opc = instr[6:0];
    f3 = instr[14:12];
    e = '0;
    e.on = 1'b1;
    e.rf_a = instr[19:15];
    e.rf_b = instr[24:20];
    e.dest = instr[11:7];
    e.is_imm = 1'b1;
    e.c_opa = 1'b1;
    e.op_a = 1'b1;         // Operand A from the register file
    case (opc)
      `OPCODE_OP: begin
        e.wb = 1'b1;
        e.c_alu = 1'b1;
        e.alu_sel = {instr[30], f3};
        e.c_imm = 1'b1;      // No immediate, so zero
        e.is_imm = 1'b0;
        e.c_rf_a = 1'b1;
        e.c_rf_b = 1'b1;
        e.c_dest = 1'b1;
      end
      `OPCODE_OPIMM: begin
        e.wb = 1'b1;
        e.c_alu = 1'b1;
        e.c_imm = 1'b1;
        e.c_rf_a = 1'b1;
        e.c_dest = 1'b1;
        if (f3 == `FUNCT3_SHIFT_L || f3 == `FUNCT3_SHIFT_R) begin
          e.alu_sel = {instr[30], f3};
          e.imm = {27'b0, instr[24:20]};
        end else begin
          e.alu_sel = {1'b0, f3};
          e.imm = {{20{instr[31]}}, instr[31:20]};
        end
      end
      `OPCODE_LUI, `OPCODE_AUIPC: begin
        e.wb = 1'b1;
        e.use_pc = (opc == `OPCODE_AUIPC);
        e.c_imm = 1'b1;
        e.imm = {instr[31:12], 12'b0};
        e.c_dest = 1'b1;
      end
      `OPCODE_LOAD: begin
        e.c_alu = 1'b1;
        e.alu_sel = `ALU_OP_ADD;  // Address is rs1 plus offset
        e.c_imm = 1'b1;
        e.imm = {{20{instr[31]}}, instr[31:20]};
        e.c_rf_a = 1'b1;
      end
      `OPCODE_STORE: begin
        e.c_imm = 1'b1;
        e.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        e.c_rf_a = 1'b1;
        e.c_rf_b = 1'b1;
      end
      `OPCODE_MISCMEM, `OPCODE_SYSTEM: begin
        e.op_a = 1'b0;
        e.c_imm = 1'b1;        // No-op, zero immediate
      end
      default: begin
        e.op_a = 1'b0;
        e.illegal = 1'b1;
      end
    endcase
    return e;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  // Holds one instruction until the decoder takes it
  task automatic issue_instr(input word_t instr);
    exp_t       main_e;
    exp_t       e;
    logic [6:0] opc;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       mem_op;
    logic       use1;
    logic       use2;
    logic       hz;
    int         len;
    int         step;
    int         k;
    logic       accepted;
    opc = instr[6:0];
    rd = instr[11:7];
    rs1 = instr[19:15];
    rs2 = instr[24:20];
    mem_op = (opc == `OPCODE_LOAD) || (opc == `OPCODE_STORE);
    use1 = (opc == `OPCODE_OP) || (opc == `OPCODE_OPIMM) || mem_op;
    use2 = (opc == `OPCODE_OP) || (opc == `OPCODE_STORE);
    hz = (use1 && rs1 != '0 && rs1 == prev_rd_m) ||
         (use2 && rs2 != '0 && rs2 == prev_rd_m);
    len = (opc == `OPCODE_LOAD) ? 5 : (opc == `OPCODE_STORE) ? 2 : 1;
    if (hz) len = len + 1;
    main_e = decode_model(instr);
    k = 0;
    accepted = 1'b0;
    while (!accepted) begin
      step = hz ? k - 1 : k;  // Step -1 is the stall cycle
      e = '0;
      if (step == 0) begin
        e = main_e;
      end else if (step == 1 && mem_op) begin
        e.lsu_v = 1'b1;        // LSU request cycle
        e.c_lsu = 1'b1;
        e.lsu = {opc[5], instr[14:12]};
        if (opc == `OPCODE_LOAD) begin
          e.c_lrd = 1'b1;
          e.lsu_rd = rd;
        end else begin
          e.c_opb = 1'b1;
          e.op_b = 1'b1;
        end
      end
      e.on = 1'b1;
      e.rdy = (k == len - 1);
      e.addr = pc;
      instr_i = instr;
      instr_valid_i = 1'b1;
      instr_addr_i = pc;
      exp_next = e;
      last_ill = e.illegal;
      @(negedge clk_i);
      accepted = ready_o;
      @(posedge clk_i);
      #1;
      k++;
    end
    prev_rd_m = (opc == `OPCODE_STORE) ? '0 : rd;
    pc = pc + 4;
  endtask

  task automatic idle_cycles(input int n);
    exp_t e;
    repeat (n) begin
      e = '0;
      e.on = 1'b1;
      e.rdy = 1'b1;
      e.illegal = last_ill;  // Held while nothing is valid
      e.addr = pc;
      instr_i = $random(seed);
      instr_valid_i = 1'b0;
      instr_addr_i = pc;
      exp_next = e;
      prev_rd_m = '0;
      @(posedge clk_i);
      #1;
    end
  endtask

  // Random word with registers x0..x7, so hazards come up often
  task automatic make_instr(input int kind, output word_t w);
    word_t tmp;
    w = $random(seed);
    tmp = $random(seed);
    w[11:7] = {2'b00, tmp[2:0]};
    w[19:15] = {2'b00, tmp[5:3]};
    w[24:20] = {2'b00, tmp[8:6]};
    case (kind)
      0: w[6:0] = `OPCODE_OP;
      1: w[6:0] = `OPCODE_OPIMM;
      2: w[6:0] = `OPCODE_LUI;
      3: w[6:0] = `OPCODE_AUIPC;
      4: w[6:0] = `OPCODE_LOAD;
      5: w[6:0] = `OPCODE_STORE;
      6: w[6:0] = tmp[9] ? `OPCODE_MISCMEM : `OPCODE_SYSTEM;
      default: w[6:0] = tmp[10] ? 7'b1101111 : 7'b1100011;  // JAL or branch
    endcase
  endtask

  initial begin
    int    kind;
    word_t w;
    rstn_i = 1'b0;
    instr_i = '0;
    instr_addr_i = '0;
    instr_valid_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rstn_i = 1'b1;
    check_bit("ready_o", 1'b1, ready_o);
    check_bit("alu_wb_o", 1'b0, alu_wb_o);
    check_bit("lsu_ctrl_valid_o", 1'b0, lsu_ctrl_valid_o);
    check_bit("use_pc_o", 1'b0, use_pc_o);
    check_bit("illegal_instr_o", 1'b0, illegal_instr_o);
    idle_cycles(2);

    // Directed cases
    issue_instr({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, `OPCODE_OP});     // add x3,x1,x2
    issue_instr({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4, `OPCODE_OP});     // sub x4,x1,x2
    issue_instr({12'hffd, 5'd2, 3'b000, 5'd5, `OPCODE_OPIMM});           // addi x5,x2,-3
    issue_instr({7'b0100000, 5'd7, 5'd1, `FUNCT3_SHIFT_R, 5'd6, `OPCODE_OPIMM});
    issue_instr({7'b0000000, 5'd31, 5'd2, `FUNCT3_SHIFT_L, 5'd7, `OPCODE_OPIMM});
    issue_instr({20'habcde, 5'd8, `OPCODE_LUI});
    issue_instr({20'h80001, 5'd9, `OPCODE_AUIPC});
    issue_instr({7'b0000000, 5'd1, 5'd9, 3'b000, 5'd10, `OPCODE_OP});    // RAW on x9
    issue_instr({12'hff8, 5'd2, 3'b010, 5'd11, `OPCODE_LOAD});           // lw x11,-8(x2)
    issue_instr({7'b0000000, 5'd11, 5'd3, 3'b010, 5'd20, `OPCODE_STORE}); // RAW on x11
    issue_instr({7'h7f, 5'd1, 5'd2, 3'b000, 5'h1f, `OPCODE_STORE});      // sb x1,-1(x2)
    issue_instr({12'h000, 5'd12, 3'b100, 5'd12, `OPCODE_LOAD});          // lbu x12,0(x12)
    issue_instr(32'h0ff0000f);  // fence
    issue_instr(32'h0000006f);  // jal, dropped, so illegal
    idle_cycles(2);
    issue_instr(32'h00000073);  // ecall

    // Random mix, kind 8 leaves a gap
    repeat (80) begin
      kind = $unsigned($random(seed)) % 9;
      if (kind == 8) begin
        idle_cycles(1 + $unsigned($random(seed)) % 2);
      end else begin
        make_instr(kind, w);
        issue_instr(w);
      end
    end
    idle_cycles(3);

    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
